// File: verification/bp_trace.txt
# fetch_pc upd_valid upd_pc upd_target upd_opcode upd_taken exp_hit exp_taken exp_target
# hex, one line per cycle; a line's update is seen by the lookups of later lines
0046 0 0000 0000 0 0 0 0 0046
0046 1 0046 1234 0 1 0 0 0046
0046 1 0086 5555 1 1 1 1 1234
0086 0 0086 5555 0 1 0 0 0086
0086 0 0000 0000 0 0 0 0 0086
0046 1 0046 1234 0 0 1 1 1234
0046 1 0046 1234 0 0 1 0 1234
0046 1 0046 1234 0 0 1 0 1234
0046 1 0046 1234 c 1 1 0 1234
0046 1 0046 1234 0 1 1 0 1234
0046 0 0000 0000 0 0 1 1 1234
0052 1 0052 a001 4 1 0 0 0052
0052 1 0092 a002 f 1 1 1 a001
0092 1 00d2 a003 0 1 1 1 a002
00d2 1 0112 a004 c 1 1 1 a003
0112 1 0052 a001 0 1 1 1 a004
0152 1 0152 a005 0 1 0 0 0152
0092 0 0000 0000 0 0 0 0 0092
0052 0 0000 0000 0 0 1 1 a001
00d2 0 0000 0000 0 0 1 1 a003
0112 0 0000 0000 0 0 1 1 a004
0152 0 0000 0000 0 0 1 1 a005
0068 1 0068 b068 0 0 0 0 0068
0068 0 0000 0000 0 0 1 0 b068
0046 0 0000 0000 0 0 1 1 1234

// File: all.f
+incdir+include
design/lc3b_types_pkg.sv
design/bp_types_pkg.sv
design/clear_sequencer.sv
design/direction_counters.sv
design/btb_plru.sv
design/btb_array.sv
design/branch_predictor.sv
verification/bp_properties.sv
verification/tb_branch_predictor.sv

// File: verification/tb_branch_predictor.sv
`include "bp_config.svh"

module tb_branch_predictor;
	import lc3b_types::*;
	import bp_types::*;

	// one cycle of stimulus with the lookup it should produce
	typedef struct packed {
		lc3b_word fetch_pc;
		bp_update_t update;
		bp_predict_t exp_pred;
	} trace_line_t;

	localparam int RESET_CYCLES = 3;
	localparam int MARGIN = 16;

	logic clk;
	logic reset;
	lc3b_word fetch_pc;
	bp_update_t update;
	bp_predict_t prediction;
	logic ready;

	trace_line_t trace[$];
	int cycle_limit;
	int cycle_count = 0;
	int wait_cycles;

	branch_predictor UUT (
		.clk(clk),
		.reset(reset),
		.fetch_pc(fetch_pc),
		.update(update),
		.prediction(prediction),
		.ready(ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic load_trace();
		int fd;
		int n;
		string text;
		logic [15:0] f_pc, u_pc, u_tgt, e_tgt;
		logic [3:0] u_op;
		logic u_valid, u_taken, e_hit, e_taken;
		trace_line_t line;
		fd = $fopen("verification/bp_trace.txt", "r");
		if (fd == 0) abort_run("could not open the trace file");
		while ($fgets(text, fd) > 0) begin
			// skip column notes and blank lines
			if (text.len() < 2 || text[0] == "#") continue;
			n = $sscanf(text, "%h %h %h %h %h %h %h %h %h", f_pc, u_valid, u_pc, u_tgt,
				u_op, u_taken, e_hit, e_taken, e_tgt);
			if (n != 9) abort_run("a trace line has the wrong number of columns");
			line.fetch_pc = f_pc;
			line.update.valid = u_valid;
			line.update.pc.raw = u_pc;
			line.update.target = u_tgt;
			line.update.opcode = lc3b_opcode'(u_op);
			line.update.taken = u_taken;
			line.exp_pred = '{hit: e_hit, taken: e_taken, target: e_tgt};
			trace.push_back(line);
		end
		$fclose(fd);
	endtask

	task automatic check_prediction(input int step, input bp_predict_t want);
		assert (prediction.hit === want.hit) else begin
			abort_run($sformatf("ERR prediction.hit exp=%h got=%h at step %0d",
				want.hit, prediction.hit, step));
		end
		assert (prediction.taken === want.taken) else begin
			abort_run($sformatf("ERR prediction.taken exp=%h got=%h at step %0d",
				want.taken, prediction.taken, step));
		end
		assert (prediction.target === want.target) else begin
			abort_run($sformatf("ERR prediction.target exp=%h got=%h at step %0d",
				want.target, prediction.target, step));
		end
	endtask

	// guards against a stuck run
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) abort_run("the run went past its cycle limit");
	end

	initial begin
		reset <= 1'b1;
		fetch_pc <= '0;
		update <= '0;
		wait_cycles = 0;
		load_trace();
		cycle_limit = RESET_CYCLES + `BP_CLEAR_CYCLES + trace.size() + MARGIN;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		// sweep clears one set per cycle
		@(negedge clk);
		while (!ready) begin
			wait_cycles++;
			if (wait_cycles > `BP_CLEAR_CYCLES + MARGIN) abort_run("ready never rose after reset");
			@(negedge clk);
		end
		// ready stays low for exactly one cycle per set
		assert (wait_cycles == `BP_CLEAR_CYCLES) else begin
			abort_run($sformatf("ERR ready low cycles exp=%h got=%h",
				`BP_CLEAR_CYCLES, wait_cycles));
		end
		// lookups are combinational, so sample mid cycle
		foreach (trace[i]) begin
			@(posedge clk);
			fetch_pc <= trace[i].fetch_pc;
			update <= trace[i].update;
			@(negedge clk);
			check_prediction(i, trace[i].exp_pred);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: verification/bp_properties.sv
module bp_properties (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_word fetch_pc,
	input bp_types::bp_predict_t prediction,
	input logic ready
);

	// a set still being swept must never report a hit
	hit_needs_ready: assert property (@(posedge clk) disable iff (reset)
		!ready |-> !prediction.hit)
		else $error("prediction hit raised while ready is low");

	// a miss falls through to the fetch pc
	miss_target_is_pc: assert property (@(posedge clk) disable iff (reset)
		!prediction.hit |-> (prediction.target == fetch_pc))
		else $error("miss target differs from fetch pc");

	// the sweep runs once, so ready stays up
	ready_holds: assert property (@(posedge clk) disable iff (reset)
		ready |=> ready)
		else $error("ready fell after it had risen");

endmodule

bind branch_predictor bp_properties u_props (
	.clk(clk),
	.reset(reset),
	.fetch_pc(fetch_pc),
	.prediction(prediction),
	.ready(ready)
);

// File: design/branch_predictor.sv
`include "bp_config.svh"

module branch_predictor (
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_word fetch_pc,
	input bp_types::bp_update_t update,
	output bp_types::bp_predict_t prediction,
	output logic ready
);
	import lc3b_types::*;
	import bp_types::*;

	lc3b_pc_u fetch_pc_u;
	logic clear_en;
	logic [`BTB_INDEX_W-1:0] clear_index;
	logic btb_hit;
	lc3b_word btb_target;
	logic dir_taken;
	logic touch;
	logic alloc;
	logic upd_en;
	btb_way_t hit_way;
	btb_way_t victim;

	assign fetch_pc_u.raw = fetch_pc;

	// post-reset sweep of every table
	clear_sequencer u_clear (
		.clk(clk), .reset(reset),
		.clear_en(clear_en), .clear_index(clear_index), .ready(ready)
	);

	btb_array u_array (
		.clk(clk), .clear_en(clear_en), .clear_index(clear_index), .ready(ready),
		.fetch_pc(fetch_pc_u), .update(update), .victim(victim),
		.hit(btb_hit), .target(btb_target), .touch(touch), .alloc(alloc),
		.hit_way(hit_way), .upd_en(upd_en)
	);

	// replacement state follows the write-back index
	btb_plru u_plru (
		.clk(clk), .reset(reset), .clear_en(clear_en), .clear_index(clear_index),
		.upd_index(update.pc.fields.index), .touch(touch), .alloc(alloc),
		.hit_way(hit_way), .victim(victim)
	);

	direction_counters u_dir (
		.clk(clk), .reset(reset), .clear_en(clear_en), .clear_index(clear_index),
		.lookup_index(fetch_pc_u.fields.index), .upd_en(upd_en),
		.upd_index(update.pc.fields.index), .upd_taken(update.taken), .taken(dir_taken)
	);

	// direction only counts when the btb supplies a target
	assign prediction = '{hit: btb_hit, taken: btb_hit && dir_taken, target: btb_target};

endmodule

// File: design/btb_array.sv
`include "bp_config.svh"

module btb_array (
	input logic clk,
	input logic clear_en,
	input logic [`BTB_INDEX_W-1:0] clear_index,
	input logic ready,
	input lc3b_types::lc3b_pc_u fetch_pc,
	input bp_types::bp_update_t update,
	input bp_types::btb_way_t victim,
	output logic hit,
	output lc3b_types::lc3b_word target,
	output logic touch,
	output logic alloc,
	output bp_types::btb_way_t hit_way,
	output logic upd_en
);
	import lc3b_types::*;
	import bp_types::*;

	btb_entry_t entry [`BTB_LINES][`BTB_WAYS];

	logic [`BTB_INDEX_W-1:0] look_index;
	logic [`BTB_INDEX_W-1:0] upd_index;
	logic [`BTB_WAYS-1:0] look_match;
	logic [`BTB_WAYS-1:0] upd_match;
	btb_way_t look_way;
	logic upd_hit;
	logic is_branch;

	assign look_index = fetch_pc.fields.index;
	assign upd_index = update.pc.fields.index;

	// fetch and write-back compare their own sets in parallel
	always_comb begin
		for (int w = 0; w < `BTB_WAYS; w++) begin
			look_match[w] = entry[look_index][w].valid &&
				(entry[look_index][w].tag == fetch_pc.fields.tag);
			upd_match[w] = entry[upd_index][w].valid &&
				(entry[upd_index][w].tag == update.pc.fields.tag);
		end
	end

	// scan downward so the lowest matching way wins
	always_comb begin
		look_way = '0;
		hit_way = '0;
		for (int w = `BTB_WAYS - 1; w >= 0; w--) begin
			if (look_match[w]) begin
				look_way = btb_way_t'(w);
			end
			if (upd_match[w]) begin
				hit_way = btb_way_t'(w);
			end
		end
	end

	// no hits until the sweep has finished
	assign hit = ready && (|look_match);
	// on a miss fetch just falls through to its own pc
	assign target = hit ? entry[look_index][look_way].target : fetch_pc.raw;

	// only control transfers train the btb
	always_comb begin
		case (update.opcode)
			op_br, op_jmp, op_jsr, op_trap: is_branch = 1'b1;
			default: is_branch = 1'b0;
		endcase
	end

	assign upd_hit = |upd_match;
	assign upd_en = update.valid && ready && is_branch;
	assign touch = upd_en && upd_hit;
	assign alloc = upd_en && !upd_hit;

	always_ff @(posedge clk) begin
		if (clear_en) begin
			// invalidate the whole set
			for (int w = 0; w < `BTB_WAYS; w++) begin
				entry[clear_index][w].valid <= 1'b0;
			end
		end else if (alloc) begin
			// miss fills the way chosen by the plru
			entry[upd_index][victim] <= '{
				valid: 1'b1,
				tag: update.pc.fields.tag,
				target: update.target
			};
		end
	end

endmodule

// File: design/btb_plru.sv
`include "bp_config.svh"

module btb_plru (
	input logic clk,
	input logic reset,
	input logic clear_en,
	input logic [`BTB_INDEX_W-1:0] clear_index,
	input logic [`BTB_INDEX_W-1:0] upd_index,
	input logic touch,
	input logic alloc,
	input bp_types::btb_way_t hit_way,
	output bp_types::btb_way_t victim
);
	import bp_types::*;

	// tree bit positions
	localparam int ROOT = 2;
	// chooses between ways 0 and 1
	localparam int LEFT = 1;
	// chooses between ways 2 and 3
	localparam int RIGHT = 0;

	logic [2:0] tree [`BTB_LINES];
	logic [2:0] cur;
	btb_way_t used_way;

	assign cur = tree[upd_index];

	// root high picks the left pair
	always_comb begin
		if (cur[ROOT]) begin
			victim = cur[LEFT] ? 2'd0 : 2'd1;
		end else begin
			victim = cur[RIGHT] ? 2'd2 : 2'd3;
		end
	end

	// allocation marks the victim as just used
	assign used_way = alloc ? victim : hit_way;

	// point the tree away from the used way
	always_ff @(posedge clk) begin
		if (reset || clear_en) begin
			tree[clear_index] <= '0;
		end else if (touch || alloc) begin
			case (used_way)
				2'd0: tree[upd_index] <= {1'b0, 1'b0, cur[RIGHT]};
				2'd1: tree[upd_index] <= {1'b0, 1'b1, cur[RIGHT]};
				2'd2: tree[upd_index] <= {1'b1, cur[LEFT], 1'b0};
				default: tree[upd_index] <= {1'b1, cur[LEFT], 1'b1};
			endcase
		end
	end

endmodule

// File: design/direction_counters.sv
`include "bp_config.svh"

module direction_counters (
	input logic clk,
	input logic reset,
	input logic clear_en,
	input logic [`BTB_INDEX_W-1:0] clear_index,
	input logic [`BTB_INDEX_W-1:0] lookup_index,
	input logic upd_en,
	input logic [`BTB_INDEX_W-1:0] upd_index,
	input logic upd_taken,
	output logic taken
);

	// bimodal table indexed by btb set
	logic [`CTR_W-1:0] ctr [`BTB_LINES];
	logic [`CTR_W-1:0] upd_ctr;

	// prediction is the counter msb
	assign taken = ctr[lookup_index][`CTR_W-1];

	// current value of the set being trained
	assign upd_ctr = ctr[upd_index];

	always_ff @(posedge clk) begin
		if (reset || clear_en) begin
			// sweep loads weakly not-taken
			ctr[clear_index] <= `CTR_INIT;
		end else if (upd_en) begin
			if (upd_taken) begin
				// saturate at strongly taken
				if (upd_ctr != '1) begin
					ctr[upd_index] <= upd_ctr + 1'b1;
				end
			end else begin
				// saturate at strongly not-taken
				if (upd_ctr != '0) begin
					ctr[upd_index] <= upd_ctr - 1'b1;
				end
			end
		end
	end

endmodule

// File: design/clear_sequencer.sv
`include "bp_config.svh"

module clear_sequencer (
	input logic clk,
	input logic reset,
	output logic clear_en,
	output logic [`BTB_INDEX_W-1:0] clear_index,
	output logic ready
);

	typedef enum logic {
		CLEARING,
		RUN
	} state_t;

	state_t state;

	// walk the sets once after reset then stay in run
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CLEARING;
			clear_index <= '0;
		end else begin
			case (state)
				CLEARING: begin
					// wraps back to zero on the last set
					clear_index <= clear_index + 1'b1;
					if (clear_index == (`BP_CLEAR_CYCLES - 1)) begin
						state <= RUN;
					end
				end
				default: begin
					state <= RUN;
				end
			endcase
		end
	end

	// one set is wiped on every clearing cycle
	assign clear_en = (state == CLEARING);
	// updates and hits wait for this
	assign ready = (state == RUN);

endmodule

// File: design/bp_types_pkg.sv
`include "bp_config.svh"

package bp_types;

	// way number inside one set
	typedef logic [$clog2(`BTB_WAYS)-1:0] btb_way_t;

	// update from the write-back stage
	typedef struct packed {
		// valid instruction strobe
		logic valid;
		lc3b_types::lc3b_pc_u pc;
		// resolved branch target
		lc3b_types::lc3b_word target;
		lc3b_types::lc3b_opcode opcode;
		// resolved direction
		logic taken;
	} bp_update_t;

	// lookup result returned to fetch
	typedef struct packed {
		logic hit;
		logic taken;
		// stored target on a hit and the fetch pc on a miss
		lc3b_types::lc3b_word target;
	} bp_predict_t;

	// one btb way
	typedef struct packed {
		logic valid;
		logic [`BTB_TAG_W-1:0] tag;
		lc3b_types::lc3b_word target;
	} btb_entry_t;

endpackage

// File: design/lc3b_types_pkg.sv
`include "bp_config.svh"

package lc3b_types;

	typedef logic [15:0] lc3b_word;

	// lc3b instruction opcodes in ir[15:12]
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// btb view of a pc
	typedef struct packed {
		logic [`BTB_TAG_W-1:0] tag;
		logic [`BTB_INDEX_W-1:0] index;
		// instructions are word aligned so this bit is ignored
		logic bsel;
	} lc3b_pc_fields_t;

	// same pc word seen raw or split for the btb
	typedef union packed {
		lc3b_word raw;
		lc3b_pc_fields_t fields;
	} lc3b_pc_u;

endpackage

// File: include/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// btb geometry
`define BTB_LINES 32
// tree pseudo-lru needs exactly four ways
`define BTB_WAYS 4

// pc split into tag, set index and byte select
`define BTB_TAG_W 10
`define BTB_INDEX_W 5

// bimodal direction counters
`define CTR_W 2
// weakly not-taken
`define CTR_INIT 2'b01

// one set wiped per cycle after reset
`define BP_CLEAR_CYCLES `BTB_LINES

`endif
